// File: vlog.f
logic/calc_cfg_pkg.sv
logic/calc_isa_pkg.sv
logic/calc_regfile.sv
logic/calc_issue.sv
logic/calc_int_pipe.sv
logic/calc_mul_pipe.sv
logic/calc_completion.sv
logic/calc_top.sv
verification/calc_props.sv
verification/calc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the calculator testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module calc_tb -Mdir obj_dir -f vlog.f

status=0
./obj_dir/Vcalc_tb 2>&1 | tee sim.log || status=$?

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: verification/calc_tb.sv
/*
 * Testbench for calc_top with a seeded random program and flushes,
 * an in-order register model and commit and writeback checks
 */
`timescale 1ns/1ps
`default_nettype none

module calc_tb;

  localparam int cycles_lp = 400;
  localparam int reset_lp  = 4;
  localparam int drain_lp  = 6;
  localparam int period_lp = 20;

  logic                    clk_i, reset_i, dispatch_v_i, flush_i;
  calc_cfg_pkg::pc_t       dispatch_pc_i;
  calc_isa_pkg::op_e       dispatch_op_i;
  calc_cfg_pkg::reg_addr_t dispatch_rs1_i, dispatch_rs2_i, dispatch_rd_i;
  calc_cfg_pkg::word_t     dispatch_imm_i;
  logic                    commit_v_o, iwb_v_o;
  calc_cfg_pkg::pc_t       commit_pc_o;
  calc_cfg_pkg::reg_addr_t iwb_addr_o;
  calc_cfg_pkg::word_t     iwb_data_o;

  int                      seed, edge_cnt;
  calc_cfg_pkg::pc_t       pc_next;
  logic                    last_mul_v;
  calc_cfg_pkg::reg_addr_t last_mul_rd;
  calc_cfg_pkg::word_t     model_regs [calc_cfg_pkg::reg_count_lp];

  // Expected commits and writebacks tagged with the dispatch edge
  calc_cfg_pkg::pc_t       commit_pc_q[$];
  int                      commit_edge_q[$], wb_edge_q[$];
  calc_cfg_pkg::reg_addr_t wb_rd_q[$];
  // Old destination value lets a flush undo the model write
  calc_cfg_pkg::word_t     wb_data_q[$], wb_old_q[$];

  calc_top calc_top_i (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #(period_lp / 2) clk_i = ~clk_i;
    end

  initial
    begin
      #(2 * cycles_lp * period_lp);
      $display("Timeout: the run did not finish within the watchdog limit");
      $display("=== FAIL ===");
      $fatal(1);
    end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual)
      else report_failure($sformatf("Mismatch %s expected %h actual %h",
                                    name, expected, actual));
  endtask

  function automatic calc_cfg_pkg::word_t alu_model(input calc_isa_pkg::op_e op,
                                                    input calc_cfg_pkg::word_t a,
                                                    input calc_cfg_pkg::word_t b);
    case (op)
      calc_isa_pkg::op_add,
      calc_isa_pkg::op_addi: return a + b;
      calc_isa_pkg::op_sub:  return a - b;
      calc_isa_pkg::op_and:  return a & b;
      calc_isa_pkg::op_or:   return a | b;
      calc_isa_pkg::op_xor:  return a ^ b;
      calc_isa_pkg::op_sll:  return a << b[4:0];
      calc_isa_pkg::op_srl:  return a >> b[4:0];
      calc_isa_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_isa_pkg::op_mul:  return a * b;
      default:               return '0;
    endcase
  endfunction

  // Execute the instruction sampled at this edge on the model
  task automatic record_dispatch();
    calc_cfg_pkg::word_t a, b, res;
    a = model_regs[dispatch_rs1_i];
    b = (dispatch_op_i == calc_isa_pkg::op_addi) ? dispatch_imm_i
                                                 : model_regs[dispatch_rs2_i];
    res = alu_model(dispatch_op_i, a, b);
    commit_pc_q.push_back(dispatch_pc_i);
    commit_edge_q.push_back(edge_cnt);
    if (dispatch_rd_i != '0)
      begin
        wb_rd_q.push_back(dispatch_rd_i);
        wb_data_q.push_back(res);
        wb_old_q.push_back(model_regs[dispatch_rd_i]);
        wb_edge_q.push_back(edge_cnt);
        model_regs[dispatch_rd_i] = res;
      end
  endtask

  // Drop the instructions of this edge and the two before it
  task automatic apply_flush();
    while (commit_edge_q.size() > 0 && commit_edge_q[$] >= edge_cnt - 2)
      begin
        void'(commit_pc_q.pop_back());
        void'(commit_edge_q.pop_back());
      end
    while (wb_edge_q.size() > 0 && wb_edge_q[$] >= edge_cnt - 2)
      begin
        model_regs[wb_rd_q[$]] = wb_old_q[$];
        void'(wb_rd_q.pop_back());
        void'(wb_data_q.pop_back());
        void'(wb_old_q.pop_back());
        void'(wb_edge_q.pop_back());
      end
  endtask

  task automatic check_outputs();
    if (commit_v_o)
      begin
        assert (commit_pc_q.size() > 0)
          else report_failure("Commit seen with no instruction outstanding");
        check_value("commit_edge", commit_edge_q[0] + 3, edge_cnt);
        check_value("commit_pc", commit_pc_q[0], commit_pc_o);
        void'(commit_pc_q.pop_front());
        void'(commit_edge_q.pop_front());
      end
    else
      assert (commit_edge_q.size() == 0 || commit_edge_q[0] != edge_cnt - 3)
        else report_failure("Commit missing three edges after dispatch");
    if (iwb_v_o)
      begin
        assert (wb_rd_q.size() > 0)
          else report_failure("Writeback seen with no instruction outstanding");
        check_value("iwb_edge", wb_edge_q[0] + 4, edge_cnt);
        check_value("iwb_addr", 32'(wb_rd_q[0]), 32'(iwb_addr_o));
        check_value("iwb_data", wb_data_q[0], iwb_data_o);
        void'(wb_rd_q.pop_front());
        void'(wb_data_q.pop_front());
        void'(wb_old_q.pop_front());
        void'(wb_edge_q.pop_front());
      end
    else
      assert (wb_edge_q.size() == 0 || wb_edge_q[0] != edge_cnt - 4)
        else report_failure("Writeback missing four edges after dispatch");
  endtask

  task automatic drive_next(input logic active);
    logic [31:0]             rnd;
    logic                    go;
    calc_isa_pkg::op_e       op;
    calc_cfg_pkg::reg_addr_t rs1, rs2, rd;
    rnd = $random(seed);
    op  = calc_isa_pkg::op_e'(rnd[3:0] % 4'd10);
    rs1 = {2'b00, rnd[6:4]};
    rs2 = {2'b00, rnd[9:7]};
    rd  = {2'b00, rnd[12:10]};
    // Product is not yet forwardable one cycle after a multiply
    if (last_mul_v && (rs1 == last_mul_rd))
      rs1 = rs1 + 5'd1;
    if (last_mul_v && (rs2 == last_mul_rd))
      rs2 = rs2 + 5'd1;
    go = active && (rnd[14:13] != 2'b00);
    dispatch_v_i   <= go;
    dispatch_pc_i  <= pc_next;
    dispatch_op_i  <= op;
    dispatch_rs1_i <= rs1;
    dispatch_rs2_i <= rs2;
    dispatch_rd_i  <= rd;
    dispatch_imm_i <= $random(seed);
    flush_i        <= active && (rnd[18:15] == 4'hf);
    last_mul_v  = go && (op == calc_isa_pkg::op_mul);
    last_mul_rd = rd;
    if (go)
      pc_next = pc_next + 32'd4;
  endtask

  initial
    begin
      seed           = 57;
      edge_cnt       = 0;
      pc_next        = 32'h0000_1000;
      last_mul_v     = 1'b0;
      last_mul_rd    = '0;
      reset_i        = 1'b1;
      dispatch_v_i   = 1'b0;
      dispatch_pc_i  = '0;
      dispatch_op_i  = calc_isa_pkg::op_add;
      dispatch_rs1_i = '0;
      dispatch_rs2_i = '0;
      dispatch_rd_i  = '0;
      dispatch_imm_i = '0;
      flush_i        = 1'b0;
      for (int i = 0; i < calc_cfg_pkg::reg_count_lp; i++)
        model_regs[i] = '0;
      repeat (reset_lp) @(posedge clk_i);
      reset_i <= 1'b0;
      for (int c = 0; c < cycles_lp + drain_lp; c++)
        begin
          @(posedge clk_i);
          edge_cnt++;
          check_outputs();
          if (dispatch_v_i)
            record_dispatch();
          if (flush_i)
            apply_flush();
          drive_next(c < cycles_lp);
        end
      if (commit_pc_q.size() == 0 && wb_rd_q.size() == 0)
        begin
          $display("=== PASS ===");
          $finish;
        end
      else
        report_failure("Instructions still outstanding at the end of the run");
    end

endmodule

`default_nettype wire

// File: verification/calc_props.sv
/*
 * Concurrent checks on the completion outputs, bound into calc_completion
 */
`timescale 1ns/1ps
`default_nettype none

module calc_props
  (input  logic                       clk_i
  , input logic                       reset_i
  , input logic                       commit_v_i
  , input logic                       iwb_v_i
  , input calc_cfg_pkg::reg_addr_t    iwb_addr_i
  );

  // Writeback trails its own commit by one stage
  wb_after_commit: assert property (@(posedge clk_i) disable iff (reset_i)
    iwb_v_i |-> $past(commit_v_i))
    else $error("writeback without a commit in the previous cycle");

  wb_addr_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    iwb_v_i |-> (iwb_addr_i != '0))
    else $error("writeback addressed to register 0");

  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (!commit_v_i && !iwb_v_i))
    else $error("completion output active in the cycle after reset");

endmodule

bind calc_completion calc_props props_i
  (.clk_i(clk_i), .reset_i(reset_i), .commit_v_i(commit_v_o)
  , .iwb_v_i(iwb_v_o), .iwb_addr_i(iwb_addr_o)
  );

`default_nettype wire

// File: logic/calc_top.sv
/*
 * Integer calculator top: issue, integer and multiply pipes,
 * completion pipe and register file
 */
`timescale 1ns/1ps
`default_nettype none

module calc_top
  (input                                 clk_i
  , input                                reset_i

  , input                                dispatch_v_i
  , input  calc_cfg_pkg::pc_t            dispatch_pc_i
  , input  calc_isa_pkg::op_e            dispatch_op_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rs1_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rs2_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rd_i
  , input  calc_cfg_pkg::word_t          dispatch_imm_i
  , input                                flush_i

  , output logic                         commit_v_o
  , output calc_cfg_pkg::pc_t            commit_pc_o
  , output logic                         iwb_v_o
  , output calc_cfg_pkg::reg_addr_t      iwb_addr_o
  , output calc_cfg_pkg::word_t          iwb_data_o
  );

  calc_cfg_pkg::reg_addr_t rs1_addr, rs2_addr;
  calc_cfg_pkg::word_t     rs1_data, rs2_data;

  logic [calc_cfg_pkg::fwd_count_lp-1:0]                    fwd_v;
  calc_cfg_pkg::reg_addr_t [calc_cfg_pkg::fwd_count_lp-1:0] fwd_addr;
  calc_cfg_pkg::word_t     [calc_cfg_pkg::fwd_count_lp-1:0] fwd_data;

  logic                    res_v, res_poison, res_rd_w;
  calc_isa_pkg::op_e       res_op;
  calc_cfg_pkg::pc_t       res_pc;
  calc_cfg_pkg::reg_addr_t res_rd;
  calc_cfg_pkg::word_t     res_rs1, res_rs2;

  logic                    int_v;
  calc_cfg_pkg::word_t     int_data, mul_data;

  calc_regfile regfile
    (.clk_i(clk_i), .reset_i(reset_i)
    , .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr)
    , .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    , .w_v_i(iwb_v_o), .w_addr_i(iwb_addr_o), .w_data_i(iwb_data_o)
    );

  calc_issue issue
    (.clk_i(clk_i), .reset_i(reset_i)
    , .dispatch_v_i(dispatch_v_i), .dispatch_pc_i(dispatch_pc_i)
    , .dispatch_op_i(dispatch_op_i), .dispatch_rs1_i(dispatch_rs1_i)
    , .dispatch_rs2_i(dispatch_rs2_i), .dispatch_rd_i(dispatch_rd_i)
    , .dispatch_imm_i(dispatch_imm_i), .flush_i(flush_i)
    , .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr)
    , .rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
    , .fwd_v_i(fwd_v), .fwd_addr_i(fwd_addr), .fwd_data_i(fwd_data)
    , .res_v_o(res_v), .res_poison_o(res_poison), .res_op_o(res_op)
    , .res_pc_o(res_pc), .res_rd_o(res_rd), .res_rd_w_o(res_rd_w)
    , .res_rs1_o(res_rs1), .res_rs2_o(res_rs2)
    );

  calc_int_pipe int_pipe
    (.res_op_i(res_op), .res_rs1_i(res_rs1), .res_rs2_i(res_rs2)
    , .int_v_o(int_v), .data_o(int_data)
    );

  calc_mul_pipe mul_pipe
    (.clk_i(clk_i), .reset_i(reset_i)
    , .res_op_i(res_op), .res_rs1_i(res_rs1), .res_rs2_i(res_rs2)
    , .data_o(mul_data)
    );

  calc_completion completion
    (.clk_i(clk_i), .reset_i(reset_i), .flush_i(flush_i)
    , .res_v_i(res_v), .res_poison_i(res_poison), .res_op_i(res_op)
    , .res_pc_i(res_pc), .res_rd_i(res_rd), .res_rd_w_i(res_rd_w)
    , .int_v_i(int_v), .int_data_i(int_data), .mul_data_i(mul_data)
    , .fwd_v_o(fwd_v), .fwd_addr_o(fwd_addr), .fwd_data_o(fwd_data)
    , .commit_v_o(commit_v_o), .commit_pc_o(commit_pc_o)
    , .iwb_v_o(iwb_v_o), .iwb_addr_o(iwb_addr_o), .iwb_data_o(iwb_data_o)
    );

endmodule

`default_nettype wire

// File: logic/calc_completion.sv
/*
 * Completion pipe carrying results, destinations and poison
 * down fixed stages, with commit, writeback and the forwarding slice
 */
`timescale 1ns/1ps
`default_nettype none

module calc_completion
  (input                                 clk_i
  , input                                reset_i
  , input                                flush_i

  , input                                res_v_i
  , input                                res_poison_i
  , input  calc_isa_pkg::op_e            res_op_i
  , input  calc_cfg_pkg::pc_t            res_pc_i
  , input  calc_cfg_pkg::reg_addr_t      res_rd_i
  , input                                res_rd_w_i

  , input                                int_v_i
  , input  calc_cfg_pkg::word_t          int_data_i
  , input  calc_cfg_pkg::word_t          mul_data_i

  , output logic [calc_cfg_pkg::fwd_count_lp-1:0]                          fwd_v_o
  , output calc_cfg_pkg::reg_addr_t [calc_cfg_pkg::fwd_count_lp-1:0]       fwd_addr_o
  , output calc_cfg_pkg::word_t     [calc_cfg_pkg::fwd_count_lp-1:0]       fwd_data_o

  , output logic                         commit_v_o
  , output calc_cfg_pkg::pc_t            commit_pc_o

  , output logic                         iwb_v_o
  , output calc_cfg_pkg::reg_addr_t      iwb_addr_o
  , output calc_cfg_pkg::word_t          iwb_data_o
  );

  localparam int last_lp = calc_cfg_pkg::stage_count_lp - 1;

  logic [last_lp:0]                    v_r, v_n, poison_r, poison_n;
  logic [last_lp:0]                    rd_w_r, rd_w_n, mul_sel_r, mul_sel_n;
  calc_cfg_pkg::pc_t       [last_lp:0] pc_r, pc_n;
  calc_cfg_pkg::reg_addr_t [last_lp:0] rd_r, rd_n;
  calc_cfg_pkg::word_t     [last_lp:0] data_r, data_n;

  always_comb
    begin
      v_n[0]       = res_v_i;
      poison_n[0]  = res_poison_i | flush_i;
      pc_n[0]      = res_pc_i;
      rd_n[0]      = res_rd_i;
      rd_w_n[0]    = res_rd_w_i;
      mul_sel_n[0] = (res_op_i == calc_isa_pkg::op_mul);
      data_n[0]    = '0;
      for (int i = 1; i <= last_lp; i++)
        begin
          v_n[i]       = v_r[i-1];
          poison_n[i]  = poison_r[i-1];
          pc_n[i]      = pc_r[i-1];
          rd_n[i]      = rd_r[i-1];
          rd_w_n[i]    = rd_w_r[i-1];
          mul_sel_n[i] = mul_sel_r[i-1];
          data_n[i]    = data_r[i-1];
        end
      // Stage 0 is the oldest instruction a flush still reaches
      poison_n[1] = poison_r[0] | flush_i;
      // Single issue and fixed latencies, so at most one pipe lands per stage
      if (int_v_i)
        data_n[calc_isa_pkg::int_lat_lp-1] = int_data_i;
      if (mul_sel_r[calc_isa_pkg::mul_lat_lp-2])
        data_n[calc_isa_pkg::mul_lat_lp-1] = mul_data_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          v_r      <= '0;
          poison_r <= '0;
        end
      else
        begin
          v_r      <= v_n;
          poison_r <= poison_n;
        end
    end

  always_ff @(posedge clk_i)
    begin
      pc_r      <= pc_n;
      rd_r      <= rd_n;
      rd_w_r    <= rd_w_n;
      mul_sel_r <= mul_sel_n;
      data_r    <= data_n;
    end

  assign commit_v_o  = v_r[1] & ~poison_r[1];
  assign commit_pc_o = pc_r[1];

  assign iwb_v_o     = v_r[last_lp] & rd_w_r[last_lp] & ~poison_r[last_lp];
  assign iwb_addr_o  = rd_r[last_lp];
  assign iwb_data_o  = data_r[last_lp];

  always_comb
    begin
      for (int i = 0; i <= last_lp; i++)
        begin
          fwd_v_o[i]    = v_n[i] & rd_w_n[i] & ~poison_n[i];
          fwd_addr_o[i] = rd_n[i];
          fwd_data_o[i] = data_n[i];
        end
      // No product in stage 0 yet
      fwd_v_o[0] = fwd_v_o[0] & int_v_i;
      fwd_v_o[calc_cfg_pkg::fwd_count_lp-1]    = iwb_v_o;
      fwd_addr_o[calc_cfg_pkg::fwd_count_lp-1] = iwb_addr_o;
      fwd_data_o[calc_cfg_pkg::fwd_count_lp-1] = iwb_data_o;
    end

endmodule

`default_nettype wire

// File: logic/calc_mul_pipe.sv
/*
 * Two-cycle multiplier keeping the low word of the product
 */
`timescale 1ns/1ps
`default_nettype none

module calc_mul_pipe
  (input                         clk_i
  , input                        reset_i

  , input  calc_isa_pkg::op_e    res_op_i
  , input  calc_cfg_pkg::word_t  res_rs1_i
  , input  calc_cfg_pkg::word_t  res_rs2_i

  , output calc_cfg_pkg::word_t  data_o
  );

  localparam int half_lp = calc_cfg_pkg::data_width_lp / 2;

  calc_cfg_pkg::word_t part_lo_r, part_hi_r;
  logic                mul_v_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        mul_v_r <= 1'b0;
      else
        mul_v_r <= (res_op_i == calc_isa_pkg::op_mul);
    end

  // Partial products against each half of the second operand
  always_ff @(posedge clk_i)
    begin
      part_lo_r <= res_rs1_i * calc_cfg_pkg::word_t'(res_rs2_i[half_lp-1:0]);
      part_hi_r <= res_rs1_i * calc_cfg_pkg::word_t'(res_rs2_i[2*half_lp-1:half_lp]);
    end

  assign data_o = mul_v_r ? (part_lo_r + (part_hi_r << half_lp)) : '0;

endmodule

`default_nettype wire

// File: logic/calc_int_pipe.sv
/*
 * Single-cycle integer ALU working off the reservation register
 */
`timescale 1ns/1ps
`default_nettype none

module calc_int_pipe
  (input  calc_isa_pkg::op_e     res_op_i
  , input  calc_cfg_pkg::word_t  res_rs1_i
  , input  calc_cfg_pkg::word_t  res_rs2_i

  , output logic                 int_v_o
  , output calc_cfg_pkg::word_t  data_o
  );

  calc_isa_pkg::shamt_t shamt;

  assign shamt   = res_rs2_i[$bits(calc_isa_pkg::shamt_t)-1:0];
  assign int_v_o = (res_op_i != calc_isa_pkg::op_mul);

  always_comb
    begin
      case (res_op_i)
        calc_isa_pkg::op_add,
        calc_isa_pkg::op_addi: data_o = res_rs1_i + res_rs2_i;
        calc_isa_pkg::op_sub:  data_o = res_rs1_i - res_rs2_i;
        calc_isa_pkg::op_and:  data_o = res_rs1_i & res_rs2_i;
        calc_isa_pkg::op_or:   data_o = res_rs1_i | res_rs2_i;
        calc_isa_pkg::op_xor:  data_o = res_rs1_i ^ res_rs2_i;
        calc_isa_pkg::op_sll:  data_o = res_rs1_i << shamt;
        calc_isa_pkg::op_srl:  data_o = res_rs1_i >> shamt;
        // Signed compare giving 0 or 1
        calc_isa_pkg::op_slt:
          data_o = calc_cfg_pkg::word_t'($signed(res_rs1_i) < $signed(res_rs2_i));
        default:               data_o = '0;
      endcase
    end

endmodule

`default_nettype wire

// File: logic/calc_issue.sv
/*
 * Issue stage with operand bypass from the completion pipe
 * and the reservation register feeding EX1
 */
`timescale 1ns/1ps
`default_nettype none

module calc_issue
  (input                                 clk_i
  , input                                reset_i

  , input                                dispatch_v_i
  , input  calc_cfg_pkg::pc_t            dispatch_pc_i
  , input  calc_isa_pkg::op_e            dispatch_op_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rs1_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rs2_i
  , input  calc_cfg_pkg::reg_addr_t      dispatch_rd_i
  , input  calc_cfg_pkg::word_t          dispatch_imm_i
  , input                                flush_i

  , output calc_cfg_pkg::reg_addr_t      rs1_addr_o
  , output calc_cfg_pkg::reg_addr_t      rs2_addr_o
  , input  calc_cfg_pkg::word_t          rs1_data_i
  , input  calc_cfg_pkg::word_t          rs2_data_i

  , input  [calc_cfg_pkg::fwd_count_lp-1:0]                          fwd_v_i
  , input  calc_cfg_pkg::reg_addr_t [calc_cfg_pkg::fwd_count_lp-1:0] fwd_addr_i
  , input  calc_cfg_pkg::word_t     [calc_cfg_pkg::fwd_count_lp-1:0] fwd_data_i

  , output logic                         res_v_o
  , output logic                         res_poison_o
  , output calc_isa_pkg::op_e            res_op_o
  , output calc_cfg_pkg::pc_t            res_pc_o
  , output calc_cfg_pkg::reg_addr_t      res_rd_o
  , output logic                         res_rd_w_o
  , output calc_cfg_pkg::word_t          res_rs1_o
  , output calc_cfg_pkg::word_t          res_rs2_o
  );

  calc_cfg_pkg::word_t bypass_rs1, bypass_rs2;

  assign rs1_addr_o = dispatch_rs1_i;
  assign rs2_addr_o = dispatch_rs2_i;

  always_comb
    begin
      bypass_rs1 = rs1_data_i;
      bypass_rs2 = rs2_data_i;
      // Walk from oldest to youngest so the youngest match wins
      for (int i = calc_cfg_pkg::fwd_count_lp-1; i >= 0; i--)
        begin
          if (fwd_v_i[i] && (fwd_addr_i[i] == dispatch_rs1_i))
            bypass_rs1 = fwd_data_i[i];
          if (fwd_v_i[i] && (fwd_addr_i[i] == dispatch_rs2_i))
            bypass_rs2 = fwd_data_i[i];
        end
      if (dispatch_rs1_i == '0)
        bypass_rs1 = '0;
      if (dispatch_rs2_i == '0)
        bypass_rs2 = '0;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          res_v_o      <= 1'b0;
          res_poison_o <= 1'b0;
        end
      else
        begin
          res_v_o      <= dispatch_v_i;
          res_poison_o <= flush_i;
        end
    end

  always_ff @(posedge clk_i)
    begin
      res_op_o   <= dispatch_op_i;
      res_pc_o   <= dispatch_pc_i;
      res_rd_o   <= dispatch_rd_i;
      res_rd_w_o <= (dispatch_rd_i != '0);
      res_rs1_o  <= bypass_rs1;
      res_rs2_o  <= (dispatch_op_i == calc_isa_pkg::op_addi) ? dispatch_imm_i : bypass_rs2;
    end

endmodule

`default_nettype wire

// File: logic/calc_regfile.sv
/*
 * Integer register file, two combinational read ports and one write port
 */
`timescale 1ns/1ps
`default_nettype none

module calc_regfile
  (input                              clk_i
  , input                             reset_i

  , input  calc_cfg_pkg::reg_addr_t   rs1_addr_i
  , input  calc_cfg_pkg::reg_addr_t   rs2_addr_i
  , output calc_cfg_pkg::word_t       rs1_data_o
  , output calc_cfg_pkg::word_t       rs2_data_o

  , input                             w_v_i
  , input  calc_cfg_pkg::reg_addr_t   w_addr_i
  , input  calc_cfg_pkg::word_t       w_data_i
  );

  calc_cfg_pkg::word_t regs_r [calc_cfg_pkg::reg_count_lp];

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          for (int i = 0; i < calc_cfg_pkg::reg_count_lp; i++)
            regs_r[i] <= '0;
        end
      else if (w_v_i && (w_addr_i != '0))
        regs_r[w_addr_i] <= w_data_i;
    end

  // x0 is hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_r[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_r[rs2_addr_i];

endmodule

`default_nettype wire

// File: logic/calc_isa_pkg.sv
/*
 * Operation encoding, shift amount field and pipe latencies
 */
`default_nettype none

package calc_isa_pkg;

  typedef enum logic [3:0]
  {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_slt  = 4'd7,
    op_addi = 4'd8,
    op_mul  = 4'd9
  } op_e;

  // Shifts take the low bits of the second operand
  typedef logic [$clog2(calc_cfg_pkg::data_width_lp)-1:0] shamt_t;

  localparam int int_lat_lp = 1;
  localparam int mul_lat_lp = 2;

endpackage

`default_nettype wire

// File: logic/calc_cfg_pkg.sv
/*
 * Pipeline geometry constants and the width types shared by the calculator
 */
`default_nettype none

package calc_cfg_pkg;

  localparam int data_width_lp  = 32;
  localparam int reg_count_lp   = 32;

  // Completion stages after EX1
  localparam int stage_count_lp = 3;

  // Next value of every stage, plus the last stage as registered
  localparam int fwd_count_lp   = stage_count_lp + 1;

  typedef logic [data_width_lp-1:0]        word_t;
  typedef logic [$clog2(reg_count_lp)-1:0] reg_addr_t;
  typedef logic [31:0]                     pc_t;

endpackage

`default_nettype wire
